// ==== build.f ====
+incdir+sim
hw/bus_pkg.sv
hw/hold_timer.sv
hw/master_route.sv
hw/slave_route.sv
hw/bus_arbiter_ctrl.sv
hw/bus_interconnect_top.sv
sim/tb_bus_interconnect.sv

// ==== Bender.yml ====
package:
  name: bus_interconnect

sources:
  - files:
      - hw/bus_pkg.sv
      - hw/hold_timer.sv
      - hw/master_route.sv
      - hw/slave_route.sv
      - hw/bus_arbiter_ctrl.sv
      - hw/bus_interconnect_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_bus_interconnect.sv

// ==== sim/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// running totals for the closing report
int n_checks = 0;
int n_errors = 0;

task automatic check_sel(input string name, input bus_sel_t got, input bus_sel_t exp);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("FAILED %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_cmd(input string name, input cmd_t got, input cmd_t exp);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("FAILED %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
  end
endtask

// single routed line
task automatic check_bit(input string name, input logic got, input logic exp);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("FAILED %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
  end
endtask

`endif

// ==== sim/tb_bus_interconnect.sv ====
`timescale 1ns/1ps

module tb_bus_interconnect;

  import bus_pkg::*;

  `include "tb_checks.svh"

  localparam int HOLD_LIMIT = 24;
  localparam int N_TESTS = 40;
  localparam int WATCHDOG_CYCLES = (N_TESTS + 1) * (HOLD_LIMIT + 40);

  logic clk = 1'b0;
  logic rstN;
  slave_id_t id [N_MASTERS-1:0];
  com_t com_state [N_MASTERS-1:0];
  cmd_t cmd [N_MASTERS-1:0];
  logic done [N_MASTERS-1:0];
  logic addr [N_MASTERS-1:0];
  logic mosi [N_MASTERS-1:0];
  logic valid [N_MASTERS-1:0];
  logic last [N_MASTERS-1:0];
  logic miso [N_MASTERS-1:0];
  logic ready [N_MASTERS-1:0];
  logic s_addr [N_SLAVES:0];
  logic s_mosi [N_SLAVES:0];
  logic s_valid [N_SLAVES:0];
  logic s_last [N_SLAVES:0];
  logic s_miso [N_SLAVES:0];
  logic s_ready [N_SLAVES:0];
  bus_sel_t bus_sel;

  // master model state and expected DUT outputs
  slave_id_t req_id [N_MASTERS-1:0];
  com_t nxt_com [N_MASTERS-1:0];
  logic nxt_done [N_MASTERS-1:0];
  cmd_t exp_cmd [N_MASTERS-1:0];
  bus_sel_t exp_sel;
  logic preempt_seen;
  master_id_t last_master;
  logic [31:0] lfsr_q = 32'hb41d;

  bus_interconnect_top #(.HOLD_LIMIT(HOLD_LIMIT)) u_dut (
    .clk(clk), .rstN(rstN), .id(id), .com_state(com_state), .done(done),
    .addr(addr), .mosi(mosi), .valid(valid), .last(last), .cmd(cmd),
    .miso(miso), .ready(ready), .s_addr(s_addr), .s_mosi(s_mosi),
    .s_valid(s_valid), .s_last(s_last), .s_miso(s_miso), .s_ready(s_ready),
    .bus_sel(bus_sel)
  );

  always #4 clk = ~clk;

  ////////////////////
  // random source
  ////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    // taps 32 22 2 1
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic rand_bit();
    lfsr_q = lfsr_next(lfsr_q);
    return lfsr_q[0];
  endfunction

  function automatic int take_bits(input int n);
    int val;
    val = 0;
    for (int b = 0; b < n; b++) begin
      val = (val << 1) | int'(rand_bit());
    end
    return val;
  endfunction

  function automatic slave_id_t rand_slave();
    slave_id_t s;
    s = slave_id_t'(take_bits(2));
    while (s == '0) begin
      s = slave_id_t'(take_bits(2));
    end
    return s;
  endfunction

  ////////////////////
  // one clock of stimulus and checks
  ////////////////////
  task automatic check_routes();
    master_id_t em;
    slave_id_t es;
    logic on;
    logic hit;
    logic mine;
    {em, es} = exp_sel;
    on = (exp_sel != '0);
    for (int s = 0; s <= N_SLAVES; s++) begin
      hit = on && (es == slave_id_t'(s));
      check_bit($sformatf("s_addr[%0d]", s), s_addr[s], hit & addr[em]);
      check_bit($sformatf("s_mosi[%0d]", s), s_mosi[s], hit & mosi[em]);
      check_bit($sformatf("s_valid[%0d]", s), s_valid[s], hit & valid[em]);
      check_bit($sformatf("s_last[%0d]", s), s_last[s], hit & last[em]);
    end
    for (int m = 0; m < N_MASTERS; m++) begin
      mine = on && (em == master_id_t'(m));
      check_bit($sformatf("miso[%0d]", m), miso[m], mine & s_miso[es]);
      check_bit($sformatf("ready[%0d]", m), ready[m], mine & s_ready[es]);
    end
  endtask

  task automatic run_cycle();
    @(negedge clk);
    for (int m = 0; m < N_MASTERS; m++) begin
      id[m] = req_id[m];
      com_state[m] = nxt_com[m];
      done[m] = nxt_done[m];
      addr[m] = rand_bit();
      mosi[m] = rand_bit();
      valid[m] = rand_bit();
      last[m] = rand_bit();
    end
    for (int s = 1; s <= N_SLAVES; s++) begin
      s_miso[s] = rand_bit();
      s_ready[s] = rand_bit();
    end
    #1;
    check_sel("bus_sel", bus_sel, exp_sel);
    for (int m = 0; m < N_MASTERS; m++) begin
      check_cmd($sformatf("cmd[%0d]", m), cmd[m], exp_cmd[m]);
    end
    check_routes();
  endtask

  ////////////////////
  // one arbitration round
  ////////////////////
  task automatic run_transaction(input int t);
    master_id_t w;
    master_id_t pick;
    slave_id_t sl;
    int len;
    int ack_wait;
    int done_wait;
    logic refuse;
    string kind;
    for (int m = 0; m < N_MASTERS; m++) begin
      if (req_id[m] == '0 && rand_bit()) begin
        req_id[m] = rand_slave();
      end
    end
    if (req_id[0] == '0 && req_id[1] == '0) begin
      pick = rand_bit();
      req_id[pick] = rand_slave();
    end
    // fixed priority, except right after a preemption
    if (preempt_seen && req_id[~last_master] != '0) begin
      w = ~last_master;
    end else begin
      w = (req_id[0] != '0) ? 1'b0 : 1'b1;
    end
    preempt_seen = 1'b0;
    last_master = w;
    sl = req_id[w];
    len = 4 + take_bits(5);
    ack_wait = take_bits(2);
    done_wait = take_bits(2);
    refuse = (take_bits(2) == 0);
    exp_sel = '0;
    exp_cmd[0] = CMD_WAIT;
    exp_cmd[1] = CMD_WAIT;
    // START then ALLOC
    run_cycle();
    run_cycle();
    exp_cmd[w] = CMD_CLEAR;
    run_cycle();
    req_id[w] = '0;
    nxt_com[w] = COM_WAIT_ACK;
    repeat (ack_wait) run_cycle();
    if (refuse) begin
      kind = "refused";
      nxt_com[w] = COM_NAK;
      run_cycle();
    end else begin
      nxt_com[w] = COM_ACTIVE;
      run_cycle();
      exp_sel = {w, sl};
      for (int i = 0; i <= len && i <= HOLD_LIMIT + 1; i++) begin
        nxt_com[w] = (i == len && len <= HOLD_LIMIT) ? COM_END : COM_ACTIVE;
        exp_cmd[w] = (i > HOLD_LIMIT) ? CMD_STOP_P : CMD_CLEAR;
        run_cycle();
      end
      if (len > HOLD_LIMIT) begin
        kind = "preempted";
        repeat (done_wait) run_cycle();
        nxt_done[w] = 1'b1;
        run_cycle();
        nxt_done[w] = 1'b0;
        preempt_seen = 1'b1;
      end else begin
        kind = "released";
      end
    end
    // OVER keeps the old command for one cycle
    nxt_com[w] = COM_END;
    exp_sel = '0;
    run_cycle();
    $display("test %0d %s: master %0d slave %0d len %0d, errors %0d",
             t, kind, w, sl, len, n_errors);
  endtask

  initial begin
    rstN = 1'b0;
    exp_sel = '0;
    preempt_seen = 1'b0;
    last_master = '0;
    for (int m = 0; m < N_MASTERS; m++) begin
      id[m] = '0;
      req_id[m] = '0;
      com_state[m] = COM_END;
      nxt_com[m] = COM_END;
      done[m] = 1'b0;
      nxt_done[m] = 1'b0;
      addr[m] = 1'b0;
      mosi[m] = 1'b0;
      valid[m] = 1'b0;
      last[m] = 1'b0;
      exp_cmd[m] = CMD_WAIT;
    end
    for (int s = 0; s <= N_SLAVES; s++) begin
      s_miso[s] = 1'b0;
      s_ready[s] = 1'b0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    run_cycle();
    $display("test 0 reset: errors %0d", n_errors);
    for (int t = 1; t <= N_TESTS; t++) begin
      run_transaction(t);
    end
    exp_cmd[0] = CMD_WAIT;
    exp_cmd[1] = CMD_WAIT;
    run_cycle();
    $display("checks %0d, errors %0d, tests %0d", n_checks, n_errors, N_TESTS + 1);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog: run hung after %0d cycles without finishing", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== hw/bus_interconnect_top.sv ====
`timescale 1ns/1ps

module bus_interconnect_top #(
  parameter int HOLD_LIMIT = 1000
) (
  input  logic               clk,
  input  logic               rstN,
  // master side
  input  bus_pkg::slave_id_t id        [bus_pkg::N_MASTERS-1:0],
  input  bus_pkg::com_t      com_state [bus_pkg::N_MASTERS-1:0],
  input  logic               done      [bus_pkg::N_MASTERS-1:0],
  input  logic               addr      [bus_pkg::N_MASTERS-1:0],
  input  logic               mosi      [bus_pkg::N_MASTERS-1:0],
  input  logic               valid     [bus_pkg::N_MASTERS-1:0],
  input  logic               last      [bus_pkg::N_MASTERS-1:0],
  output bus_pkg::cmd_t      cmd       [bus_pkg::N_MASTERS-1:0],
  output logic               miso      [bus_pkg::N_MASTERS-1:0],
  output logic               ready     [bus_pkg::N_MASTERS-1:0],
  // slave side, slot 0 unused
  output logic               s_addr    [bus_pkg::N_SLAVES:0],
  output logic               s_mosi    [bus_pkg::N_SLAVES:0],
  output logic               s_valid   [bus_pkg::N_SLAVES:0],
  output logic               s_last    [bus_pkg::N_SLAVES:0],
  input  logic               s_miso    [bus_pkg::N_SLAVES:0],
  input  logic               s_ready   [bus_pkg::N_SLAVES:0],
  output bus_pkg::bus_sel_t  bus_sel
);

  logic expire;
  logic fw_addr;
  logic fw_mosi;
  logic fw_valid;
  logic fw_last;
  logic sl_miso;
  logic sl_ready;

  ////////////////////
  // control
  ////////////////////
  bus_arbiter_ctrl u_ctrl (
    .clk(clk), .rstN(rstN), .id(id), .com_state(com_state), .done(done),
    .expire(expire), .cmd(cmd), .bus_sel(bus_sel)
  );

  hold_timer #(.HOLD_LIMIT(HOLD_LIMIT)) u_timer (
    .clk(clk), .rstN(rstN), .bus_sel(bus_sel), .expire(expire)
  );

  ////////////////////
  // datapath
  ////////////////////
  master_route u_mroute (
    .bus_sel(bus_sel), .addr(addr), .mosi(mosi), .valid(valid), .last(last),
    .sl_miso(sl_miso), .sl_ready(sl_ready), .fw_addr(fw_addr), .fw_mosi(fw_mosi),
    .fw_valid(fw_valid), .fw_last(fw_last), .miso(miso), .ready(ready)
  );

  slave_route u_sroute (
    .bus_sel(bus_sel), .fw_addr(fw_addr), .fw_mosi(fw_mosi), .fw_valid(fw_valid),
    .fw_last(fw_last), .s_miso(s_miso), .s_ready(s_ready), .s_addr(s_addr),
    .s_mosi(s_mosi), .s_valid(s_valid), .s_last(s_last), .sl_miso(sl_miso),
    .sl_ready(sl_ready)
  );

endmodule

// ==== hw/bus_arbiter_ctrl.sv ====
`timescale 1ns/1ps

module bus_arbiter_ctrl (
  input  logic               clk,
  input  logic               rstN,
  input  bus_pkg::slave_id_t id        [bus_pkg::N_MASTERS-1:0],
  input  bus_pkg::com_t      com_state [bus_pkg::N_MASTERS-1:0],
  input  logic               done      [bus_pkg::N_MASTERS-1:0],
  input  logic               expire,
  output bus_pkg::cmd_t      cmd       [bus_pkg::N_MASTERS-1:0],
  output bus_pkg::bus_sel_t  bus_sel
);

  import bus_pkg::*;

  localparam int SW = $bits(slave_id_t);

  arb_state_t state;
  arb_state_t next_state;
  master_id_t cur_master;
  master_id_t pick_master;
  slave_id_t  cur_slave;
  slave_id_t  pick_slave;
  cmd_t       cmd_reg;
  logic       preempted;
  logic       any_req;
  com_t       cur_com;
  logic       cur_done;

  assign cur_com  = com_state[cur_master];
  assign cur_done = done[cur_master];
  assign any_req  = (id[0] != '0) || (id[1] != '0);

  // master 0 wins unless the last holder was preempted
  always_comb begin
    pick_master = '0;
    if (preempted && (id[~cur_master] != '0)) begin
      pick_master = ~cur_master;
    end else if (id[0] == '0) begin
      pick_master = 1'b1;
    end
    pick_slave = id[pick_master];
  end

  ////////////////////
  // next state
  ////////////////////
  always_comb begin
    next_state = state;
    case (state)
      RST:   next_state = START;
      START: if (any_req) next_state = ALLOC;
      ALLOC: next_state = ACK;
      ACK: begin
        if (cur_com == COM_NAK) begin
          next_state = OVER;
        end else if (cur_com == COM_ACTIVE) begin
          next_state = COM;
        end
      end
      COM: begin
        if (cur_com == COM_END) begin
          next_state = OVER;
        end else if (expire) begin
          next_state = DONE;
        end
      end
      DONE:    if (cur_done) next_state = OVER;
      OVER:    next_state = START;
      default: next_state = RST;
    endcase
  end

  ////////////////////
  // state and grant registers
  ////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state      <= RST;
      cur_master <= '0;
      cur_slave  <= '0;
      cmd_reg    <= CMD_WAIT;
      bus_sel    <= '0;
      preempted  <= 1'b0;
    end else begin
      state <= next_state;
      case (state)
        START: begin
          if (any_req) begin
            cur_master <= pick_master;
            cur_slave  <= pick_slave;
            preempted  <= 1'b0;
          end
        end
        ALLOC: cmd_reg <= CMD_CLEAR;
        ACK: begin
          if (cur_com == COM_ACTIVE) begin
            bus_sel <= {cur_master, cur_slave};
          end
        end
        COM: begin
          if (cur_com == COM_END) begin
            bus_sel <= '0;
          end else if (expire) begin
            cmd_reg <= CMD_STOP_P;
          end
        end
        DONE: begin
          // holder gave up the bus under force
          if (cur_done) begin
            bus_sel   <= '0;
            preempted <= 1'b1;
          end
        end
        OVER:    cmd_reg <= CMD_WAIT;
        default: cmd_reg <= CMD_WAIT;
      endcase
    end
  end

  // command only to the master in service
  always_comb begin
    for (int m = 0; m < N_MASTERS; m++) begin
      cmd[m] = (master_id_t'(m) == cur_master) ? cmd_reg : CMD_WAIT;
    end
  end

  a_idle_in_start: assert property (@(posedge clk) disable iff (!rstN)
    (state == START) |-> (bus_sel == '0));
  a_sel_has_slave: assert property (@(posedge clk) disable iff (!rstN)
    (bus_sel != '0) |-> (bus_sel[SW-1:0] != '0));

endmodule

// ==== hw/slave_route.sv ====
`timescale 1ns/1ps

module slave_route (
  input  bus_pkg::bus_sel_t bus_sel,
  input  logic              fw_addr,
  input  logic              fw_mosi,
  input  logic              fw_valid,
  input  logic              fw_last,
  input  logic              s_miso  [bus_pkg::N_SLAVES:0],
  input  logic              s_ready [bus_pkg::N_SLAVES:0],
  output logic              s_addr  [bus_pkg::N_SLAVES:0],
  output logic              s_mosi  [bus_pkg::N_SLAVES:0],
  output logic              s_valid [bus_pkg::N_SLAVES:0],
  output logic              s_last  [bus_pkg::N_SLAVES:0],
  output logic              sl_miso,
  output logic              sl_ready
);

  import bus_pkg::*;

  slave_id_t         slv;
  logic [N_SLAVES:0] hit;

  assign slv = bus_sel[$bits(slave_id_t)-1:0];

  // slot 0 is the idle code and stays dark
  always_comb begin
    for (int s = 0; s <= N_SLAVES; s++) begin
      hit[s]     = (s != 0) && (slave_id_t'(s) == slv);
      s_addr[s]  = hit[s] & fw_addr;
      s_mosi[s]  = hit[s] & fw_mosi;
      s_valid[s] = hit[s] & fw_valid;
      s_last[s]  = hit[s] & fw_last;
    end
  end

  // return path from the selected slave
  assign sl_miso  = (slv != '0) ? s_miso[slv]  : 1'b0;
  assign sl_ready = (slv != '0) ? s_ready[slv] : 1'b0;

endmodule

// ==== hw/master_route.sv ====
`timescale 1ns/1ps

module master_route (
  input  bus_pkg::bus_sel_t bus_sel,
  input  logic              addr  [bus_pkg::N_MASTERS-1:0],
  input  logic              mosi  [bus_pkg::N_MASTERS-1:0],
  input  logic              valid [bus_pkg::N_MASTERS-1:0],
  input  logic              last  [bus_pkg::N_MASTERS-1:0],
  input  logic              sl_miso,
  input  logic              sl_ready,
  output logic              fw_addr,
  output logic              fw_mosi,
  output logic              fw_valid,
  output logic              fw_last,
  output logic              miso  [bus_pkg::N_MASTERS-1:0],
  output logic              ready [bus_pkg::N_MASTERS-1:0]
);

  import bus_pkg::*;

  master_id_t mst;
  logic       active;

  // master number sits in the top bit
  assign mst    = bus_sel[$bits(bus_sel_t)-1];
  assign active = (bus_sel != '0);

  // forward lines of the granted master, quiet when idle
  always_comb begin
    fw_addr  = 1'b0;
    fw_mosi  = 1'b0;
    fw_valid = 1'b0;
    fw_last  = 1'b0;
    if (active) begin
      fw_addr  = addr[mst];
      fw_mosi  = mosi[mst];
      fw_valid = valid[mst];
      fw_last  = last[mst];
    end
  end

  // return lines reach the granted master only
  always_comb begin
    for (int m = 0; m < N_MASTERS; m++) begin
      miso[m]  = active && (master_id_t'(m) == mst) && sl_miso;
      ready[m] = active && (master_id_t'(m) == mst) && sl_ready;
    end
  end

endmodule

// ==== hw/hold_timer.sv ====
`timescale 1ns/1ps

module hold_timer #(
  parameter int HOLD_LIMIT = 1000
) (
  input  logic              clk,
  input  logic              rstN,
  input  bus_pkg::bus_sel_t bus_sel,
  output logic              expire
);

  localparam int CNT_W = $clog2(HOLD_LIMIT + 1);
  typedef logic [CNT_W-1:0] cnt_t;
  localparam cnt_t LIMIT = cnt_t'(HOLD_LIMIT);

  cnt_t cnt;
  cnt_t cnt_next;
  logic granted;

  assign granted  = (bus_sel != '0);
  // sticks at the limit until the bus goes idle
  assign cnt_next = (cnt == LIMIT) ? cnt : cnt_t'(cnt + 1'b1);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      cnt    <= '0;
      expire <= 1'b0;
    end else if (!granted) begin
      cnt    <= '0;
      expire <= 1'b0;
    end else begin
      cnt    <= cnt_next;
      expire <= (cnt_next == LIMIT);
    end
  end

endmodule

// ==== hw/bus_pkg.sv ====
package bus_pkg;

  // bus geometry, command decode assumes two masters
  localparam int N_MASTERS = 2;
  localparam int N_SLAVES  = 3;

  typedef logic [0:0] master_id_t;
  // slave 0 is the idle code
  typedef logic [1:0] slave_id_t;
  // master number on top of slave number
  typedef logic [2:0] bus_sel_t;

  // status reported by a master
  typedef logic [1:0] com_t;
  localparam com_t COM_END      = 2'b00;
  localparam com_t COM_NAK      = 2'b01;
  localparam com_t COM_WAIT_ACK = 2'b10;
  localparam com_t COM_ACTIVE   = 2'b11;

  // commands sent to a master
  typedef logic [1:0] cmd_t;
  localparam cmd_t CMD_WAIT   = 2'b00;
  localparam cmd_t CMD_STOP_S = 2'b01;
  localparam cmd_t CMD_STOP_P = 2'b10;
  localparam cmd_t CMD_CLEAR  = 2'b11;

  typedef enum logic [2:0] {
    RST, START, ALLOC, ACK, COM, DONE, OVER
  } arb_state_t;

endpackage
